//--- source/io_platform_pkg.sv
// Word-addressed bus with single-beat commands only; address bit 15 selects the host block
package io_platform_pkg;

  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int NUM_CORES = 4;
  localparam int TRACE_W   = 8;
  localparam int MEM_WORDS = 1024;

  // Derived index widths
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);
  localparam int CORE_ID_W = $clog2(NUM_CORES);

  // Address map
  localparam int              HOST_SEL_BIT     = 15;
  localparam logic [15:0]     HOST_FINISH_ADDR = 16'h8000;
  localparam logic [15:0]     HOST_TRACE_ADDR  = 16'h8001;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [NUM_CORES-1:0] core_mask_t;
  typedef logic [TRACE_W-1:0]   trace_en_t;

  typedef enum logic [1:0] {
    e_nbf_write  = 2'd0,
    e_nbf_fence  = 2'd1,
    e_nbf_finish = 2'd2
  } nbf_op_e;

  typedef enum logic [1:0] {
    e_ld_idle,
    e_ld_issue,
    e_ld_wait,
    e_ld_done
  } loader_state_e;

  typedef enum logic {
    e_arb_idle,
    e_arb_resp
  } arb_state_e;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } io_cmd_s;

  typedef struct packed {
    data_t data;
  } io_resp_s;

  typedef struct packed {
    nbf_op_e op;
    addr_t   addr;
    data_t   data;
  } nbf_rec_s;

endpackage

//--- source/nbf_loader.sv
// One record in flight at a time; response data is ignored and done_o holds until reset
module nbf_loader (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      rec_v_i,
  input  io_platform_pkg::nbf_rec_s rec_i,
  output logic                      rec_ready_o,
  output logic                      cmd_v_o,
  output io_platform_pkg::io_cmd_s  cmd_o,
  input  logic                      cmd_ready_i,
  input  logic                      resp_v_i,
  input  io_platform_pkg::io_resp_s resp_i,
  output logic                      resp_ready_o,
  output logic                      done_o
);

  io_platform_pkg::loader_state_e state_q;
  io_platform_pkg::loader_state_e state_n;
  io_platform_pkg::nbf_op_e       op_q;
  io_platform_pkg::io_cmd_s       cmd_q;
  logic                           rdy_q;
  logic                           pending_q;
  logic                           rec_fire;
  logic                           cmd_fire;
  logic                           resp_fire;
  logic                           wait_done;

  assign rec_fire     = rec_v_i & rdy_q;
  assign cmd_fire     = cmd_v_o & cmd_ready_i;
  assign resp_fire    = resp_v_i & resp_ready_o;
  assign wait_done    = ~pending_q | resp_fire;

  assign rec_ready_o  = rdy_q;
  assign cmd_v_o      = (state_q == io_platform_pkg::e_ld_issue);
  assign cmd_o        = cmd_q;
  // Always a sink for responses
  assign resp_ready_o = 1'b1;
  assign done_o       = (state_q == io_platform_pkg::e_ld_done);

  always_comb
  begin
    state_n = state_q;
    unique case (state_q)
      io_platform_pkg::e_ld_idle:
        if (rec_fire)
        begin
          if (rec_i.op == io_platform_pkg::e_nbf_write)
            state_n = io_platform_pkg::e_ld_issue;
          else
            state_n = io_platform_pkg::e_ld_wait;
        end
      io_platform_pkg::e_ld_issue:
        if (cmd_fire)
          state_n = io_platform_pkg::e_ld_wait;
      io_platform_pkg::e_ld_wait:
        if (wait_done)
          state_n = (op_q == io_platform_pkg::e_nbf_finish) ?
                    io_platform_pkg::e_ld_done : io_platform_pkg::e_ld_idle;
      default:
        state_n = io_platform_pkg::e_ld_done;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= io_platform_pkg::e_ld_idle;
      op_q      <= io_platform_pkg::e_nbf_write;
      rdy_q     <= 1'b0;
      pending_q <= 1'b0;
    end
    else
    begin
      state_q   <= state_n;
      rdy_q     <= (state_n == io_platform_pkg::e_ld_idle);
      if (rec_fire)
        op_q <= rec_i.op;
      if (cmd_fire)
        pending_q <= 1'b1;
      else if (resp_fire)
        pending_q <= 1'b0;
    end
  end

  // Write command payload
  always_ff @(posedge clk_i)
  begin
    if (rec_fire)
    begin
      cmd_q.write <= 1'b1;
      cmd_q.addr  <= rec_i.addr;
      cmd_q.data  <= rec_i.data;
    end
  end

endmodule

//--- source/word_memory.sv
// Contents are not reset; addresses wrap modulo MEM_WORDS and a write answers with its own data
module word_memory (
  input  logic                      clk_i,
  input  logic                      req_i,
  input  io_platform_pkg::io_cmd_s  cmd_i,
  output io_platform_pkg::io_resp_s resp_o
);

  io_platform_pkg::data_t                           mem [io_platform_pkg::MEM_WORDS];
  io_platform_pkg::io_resp_s                        resp_q;
  logic [io_platform_pkg::MEM_IDX_W-1:0]            idx;

  assign idx    = cmd_i.addr[io_platform_pkg::MEM_IDX_W-1:0];
  assign resp_o = resp_q;

  always_ff @(posedge clk_i)
  begin
    if (req_i)
    begin
      if (cmd_i.write)
      begin
        mem[idx]    <= cmd_i.data;
        resp_q.data <= cmd_i.data;
      end
      else
      begin
        resp_q.data <= mem[idx];
      end
    end
  end

endmodule

//--- source/host_regs.sv
// Finish bits are sticky until reset; only the two host offsets decode and writes answer zero
module host_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_i,
  input  io_platform_pkg::io_cmd_s    cmd_i,
  output io_platform_pkg::io_resp_s   resp_o,
  output io_platform_pkg::core_mask_t finish_o,
  output io_platform_pkg::trace_en_t  trace_en_o
);

  io_platform_pkg::core_mask_t finish_q;
  io_platform_pkg::trace_en_t  trace_q;
  io_platform_pkg::io_resp_s   resp_q;
  io_platform_pkg::data_t      rd_data;
  logic                        hit_finish;
  logic                        hit_trace;

  assign hit_finish = (cmd_i.addr == io_platform_pkg::HOST_FINISH_ADDR);
  assign hit_trace  = (cmd_i.addr == io_platform_pkg::HOST_TRACE_ADDR);

  always_comb
  begin
    rd_data = '0;
    if (hit_finish)
      rd_data = io_platform_pkg::data_t'(finish_q);
    else if (hit_trace)
      rd_data = io_platform_pkg::data_t'(trace_q);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      finish_q <= '0;
      trace_q  <= '0;
    end
    else if (req_i && cmd_i.write)
    begin
      // Low data bits name the core that finished
      if (hit_finish)
        finish_q[cmd_i.data[io_platform_pkg::CORE_ID_W-1:0]] <= 1'b1;
      if (hit_trace)
        trace_q <= cmd_i.data[io_platform_pkg::TRACE_W-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_i)
      resp_q.data <= cmd_i.write ? '0 : rd_data;
  end

  assign resp_o     = resp_q;
  assign finish_o   = finish_q;
  assign trace_en_o = trace_q;

endmodule

//--- source/io_arbiter.sv
// Round-robin over two masters with one command in flight; targets must answer one cycle after req
module io_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      m0_cmd_v_i,
  input  io_platform_pkg::io_cmd_s  m0_cmd_i,
  output logic                      m0_cmd_ready_o,
  output logic                      m0_resp_v_o,
  output io_platform_pkg::io_resp_s m0_resp_o,
  input  logic                      m0_resp_ready_i,
  input  logic                      m1_cmd_v_i,
  input  io_platform_pkg::io_cmd_s  m1_cmd_i,
  output logic                      m1_cmd_ready_o,
  output logic                      m1_resp_v_o,
  output io_platform_pkg::io_resp_s m1_resp_o,
  input  logic                      m1_resp_ready_i,
  output logic                      mem_req_o,
  output logic                      host_req_o,
  output io_platform_pkg::io_cmd_s  tgt_cmd_o,
  input  io_platform_pkg::io_resp_s mem_resp_i,
  input  io_platform_pkg::io_resp_s host_resp_i
);

  io_platform_pkg::arb_state_e state_q;
  io_platform_pkg::arb_state_e state_n;
  io_platform_pkg::io_resp_s   resp_q;
  logic                        owner_q;
  logic                        last_m1_q;
  logic                        host_q;
  logic                        resp_v_q;
  logic                        idle;
  logic                        grant0;
  logic                        grant1;
  logic                        cmd_fire;
  logic                        sel_host;
  logic                        resp_due;
  logic                        resp_take;

  assign idle     = (state_q == io_platform_pkg::e_arb_idle);

  // Master 1 wins a tie only when master 0 was granted last
  assign grant0   = idle & m0_cmd_v_i & (~m1_cmd_v_i | last_m1_q);
  assign grant1   = idle & m1_cmd_v_i & ~grant0;
  assign cmd_fire = grant0 | grant1;

  assign m0_cmd_ready_o = grant0;
  assign m1_cmd_ready_o = grant1;

  assign tgt_cmd_o  = grant1 ? m1_cmd_i : m0_cmd_i;
  assign sel_host   = tgt_cmd_o.addr[io_platform_pkg::HOST_SEL_BIT];
  assign mem_req_o  = cmd_fire & ~sel_host;
  assign host_req_o = cmd_fire & sel_host;

  // Target answer is on its port the cycle after the strobe
  assign resp_due  = (state_q == io_platform_pkg::e_arb_resp) & ~resp_v_q;
  assign resp_take = resp_v_q & (owner_q ? m1_resp_ready_i : m0_resp_ready_i);

  assign m0_resp_v_o = resp_v_q & ~owner_q;
  assign m1_resp_v_o = resp_v_q & owner_q;
  assign m0_resp_o   = resp_q;
  assign m1_resp_o   = resp_q;

  always_comb
  begin
    state_n = state_q;
    unique case (state_q)
      io_platform_pkg::e_arb_idle:
        if (cmd_fire)
          state_n = io_platform_pkg::e_arb_resp;
      io_platform_pkg::e_arb_resp:
        if (resp_take)
          state_n = io_platform_pkg::e_arb_idle;
      default:
        state_n = io_platform_pkg::e_arb_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= io_platform_pkg::e_arb_idle;
      owner_q   <= 1'b0;
      last_m1_q <= 1'b1;
      host_q    <= 1'b0;
      resp_v_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_n;
      if (cmd_fire)
      begin
        owner_q   <= grant1;
        last_m1_q <= grant1;
        host_q    <= sel_host;
      end
      if (resp_due)
        resp_v_q <= 1'b1;
      else if (resp_take)
        resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (resp_due)
      resp_q <= host_q ? host_resp_i : mem_resp_i;
  end

endmodule

//--- source/io_platform.sv
// Processor port and nbf loader share memory and host registers; one command in flight overall
module io_platform (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        proc_cmd_v_i,
  input  io_platform_pkg::io_cmd_s    proc_cmd_i,
  output logic                        proc_cmd_ready_o,
  output logic                        proc_resp_v_o,
  output io_platform_pkg::io_resp_s   proc_resp_o,
  input  logic                        proc_resp_ready_i,
  input  logic                        rec_v_i,
  input  io_platform_pkg::nbf_rec_s   rec_i,
  output logic                        rec_ready_o,
  output logic                        done_o,
  output io_platform_pkg::core_mask_t finish_o,
  output io_platform_pkg::trace_en_t  trace_en_o
);

  io_platform_pkg::io_cmd_s  ld_cmd;
  io_platform_pkg::io_resp_s ld_resp;
  io_platform_pkg::io_cmd_s  tgt_cmd;
  io_platform_pkg::io_resp_s mem_resp;
  io_platform_pkg::io_resp_s host_resp;
  logic                      ld_cmd_v;
  logic                      ld_cmd_ready;
  logic                      ld_resp_v;
  logic                      ld_resp_ready;
  logic                      mem_req;
  logic                      host_req;

  nbf_loader u_loader (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rec_v_i      (rec_v_i),
    .rec_i        (rec_i),
    .rec_ready_o  (rec_ready_o),
    .cmd_v_o      (ld_cmd_v),
    .cmd_o        (ld_cmd),
    .cmd_ready_i  (ld_cmd_ready),
    .resp_v_i     (ld_resp_v),
    .resp_i       (ld_resp),
    .resp_ready_o (ld_resp_ready),
    .done_o       (done_o)
  );

  // Master 0 is the processor port, master 1 the loader
  io_arbiter u_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .m0_cmd_v_i      (proc_cmd_v_i),
    .m0_cmd_i        (proc_cmd_i),
    .m0_cmd_ready_o  (proc_cmd_ready_o),
    .m0_resp_v_o     (proc_resp_v_o),
    .m0_resp_o       (proc_resp_o),
    .m0_resp_ready_i (proc_resp_ready_i),
    .m1_cmd_v_i      (ld_cmd_v),
    .m1_cmd_i        (ld_cmd),
    .m1_cmd_ready_o  (ld_cmd_ready),
    .m1_resp_v_o     (ld_resp_v),
    .m1_resp_o       (ld_resp),
    .m1_resp_ready_i (ld_resp_ready),
    .mem_req_o       (mem_req),
    .host_req_o      (host_req),
    .tgt_cmd_o       (tgt_cmd),
    .mem_resp_i      (mem_resp),
    .host_resp_i     (host_resp)
  );

  word_memory u_memory (
    .clk_i  (clk_i),
    .req_i  (mem_req),
    .cmd_i  (tgt_cmd),
    .resp_o (mem_resp)
  );

  host_regs u_host (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (host_req),
    .cmd_i      (tgt_cmd),
    .resp_o     (host_resp),
    .finish_o   (finish_o),
    .trace_en_o (trace_en_o)
  );

endmodule

//--- bench/tb_clock.sv
// Free-running clock of period 8; reset is released on a falling edge after 5 rising edges
module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- bench/tb_io_platform.sv
// Drives both masters at the top level; memory reads only target words written earlier in the run
module tb_io_platform;

  logic                        clk;
  logic                        rst_n;
  logic                        proc_cmd_v;
  io_platform_pkg::io_cmd_s    proc_cmd;
  logic                        proc_cmd_ready;
  logic                        proc_resp_v;
  io_platform_pkg::io_resp_s   proc_resp;
  logic                        proc_resp_ready;
  logic                        rec_v;
  io_platform_pkg::nbf_rec_s   rec;
  logic                        rec_ready;
  logic                        done;
  io_platform_pkg::core_mask_t finish;
  io_platform_pkg::trace_en_t  trace_en;

  // Reference state of memory and host registers
  io_platform_pkg::data_t      mem_model [io_platform_pkg::MEM_WORDS];
  io_platform_pkg::core_mask_t finish_model = '0;
  io_platform_pkg::trace_en_t  trace_model  = '0;
  io_platform_pkg::data_t      exp_q [$];
  io_platform_pkg::addr_t      ld_addrs [$];
  io_platform_pkg::addr_t      pr_addrs [$];
  io_platform_pkg::data_t      held;
  io_platform_pkg::data_t      expected;

  logic [31:0] seed         = 32'h7fe8_7254;
  string       test_name    = "reset";
  logic        bp_on        = 1'b0;
  logic        pending      = 1'b0;
  int          since        = 0;
  int          issued       = 0;
  int          cycles       = 0;
  int          rec_accepts  = 0;
  int          proc_accepts = 0;
  int          proc_takes   = 0;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  io_platform DUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .proc_cmd_v_i      (proc_cmd_v),
    .proc_cmd_i        (proc_cmd),
    .proc_cmd_ready_o  (proc_cmd_ready),
    .proc_resp_v_o     (proc_resp_v),
    .proc_resp_o       (proc_resp),
    .proc_resp_ready_i (proc_resp_ready),
    .rec_v_i           (rec_v),
    .rec_i             (rec),
    .rec_ready_o       (rec_ready),
    .done_o            (done),
    .finish_o          (finish),
    .trace_en_o        (trace_en)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input io_platform_pkg::data_t exp,
                                 input io_platform_pkg::data_t act);
    abort_run($sformatf("mismatch %s expected %08h actual %08h", test_name, exp, act));
  endtask

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Upper selects the top half of memory, so two masters can stay disjoint
  function automatic io_platform_pkg::addr_t rand_addr(input logic upper);
    logic [31:0] r;
    r = next_random();
    return {6'b0, upper, r[8:0]};
  endfunction

  function automatic io_platform_pkg::data_t expected_read(input io_platform_pkg::addr_t addr);
    if (!addr[io_platform_pkg::HOST_SEL_BIT])
      return mem_model[addr[io_platform_pkg::MEM_IDX_W-1:0]];
    if (addr == io_platform_pkg::HOST_FINISH_ADDR)
      return io_platform_pkg::data_t'(finish_model);
    if (addr == io_platform_pkg::HOST_TRACE_ADDR)
      return io_platform_pkg::data_t'(trace_model);
    return '0;
  endfunction

  function automatic void apply_write(input io_platform_pkg::addr_t addr,
                                      input io_platform_pkg::data_t data);
    if (!addr[io_platform_pkg::HOST_SEL_BIT])
      mem_model[addr[io_platform_pkg::MEM_IDX_W-1:0]] = data;
    else if (addr == io_platform_pkg::HOST_FINISH_ADDR)
      finish_model[data[1:0]] = 1'b1;
    else if (addr == io_platform_pkg::HOST_TRACE_ADDR)
      trace_model = data[io_platform_pkg::TRACE_W-1:0];
  endfunction

  // Called on a falling edge; returns on the falling edge after the response is taken
  task automatic proc_access(input logic wr, input io_platform_pkg::addr_t addr,
                             input io_platform_pkg::data_t data);
    int          target;
    int unsigned span;
    target = proc_accepts + 1;
    issued++;
    if (wr)
    begin
      apply_write(addr, data);
      exp_q.push_back(addr[io_platform_pkg::HOST_SEL_BIT] ? '0 : data);
    end
    else
      exp_q.push_back(expected_read(addr));
    proc_cmd_v = 1'b1;
    proc_cmd   = {wr, addr, data};
    while (proc_accepts < target)
      @(negedge clk);
    // Under back-pressure the command stays offered while the response is stalled
    if (bp_on)
    begin
      proc_resp_ready = 1'b0;
      span = next_random() % 6;
      repeat (span) @(negedge clk);
    end
    proc_cmd_v      = 1'b0;
    proc_resp_ready = 1'b1;
    while (proc_takes < target)
      @(negedge clk);
  endtask

  task automatic load_record(input io_platform_pkg::nbf_op_e op,
                             input io_platform_pkg::addr_t addr,
                             input io_platform_pkg::data_t data);
    int target;
    target = rec_accepts + 1;
    issued++;
    if (op == io_platform_pkg::e_nbf_write)
      apply_write(addr, data);
    rec_v = 1'b1;
    rec   = {op, addr, data};
    while (rec_accepts < target)
      @(negedge clk);
    rec_v = 1'b0;
  endtask

  task automatic wait_loader_idle();
    while (!rec_ready)
      @(negedge clk);
  endtask

  // Response checks on the processor port, sampled on the rising edge
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (rec_v && rec_ready)
        rec_accepts++;
      if (pending)
      begin
        since++;
        assert (!proc_cmd_ready)
          else abort_run($sformatf("%s: command accepted while a response was pending",
                                   test_name));
        assert (proc_resp_v == (since >= 2))
          else abort_run($sformatf("%s: response valid not high from one cycle after accept",
                                   test_name));
        if (since == 2)
          held = proc_resp.data;
        assert (since < 2 || proc_resp.data == held)
          else abort_run($sformatf("%s: response data changed while stalled", test_name));
        if (proc_resp_v && proc_resp_ready)
        begin
          pending = 1'b0;
          proc_takes++;
          expected = exp_q.pop_front();
          assert (proc_resp.data == expected)
            else report_mismatch(expected, proc_resp.data);
        end
      end
      else
      begin
        assert (!proc_resp_v)
          else abort_run($sformatf("%s: response valid with no command", test_name));
      end
      if (proc_cmd_v && proc_cmd_ready)
      begin
        pending = 1'b1;
        since   = 0;
        proc_accepts++;
      end
    end
  end

  initial
  begin
    while (cycles <= 200 * issued + 1000)
    begin
      @(posedge clk);
      cycles++;
    end
    abort_run("timeout: the run did not complete in the allowed number of cycles");
  end

  initial
  begin
    io_platform_pkg::addr_t a;
    io_platform_pkg::data_t d;
    int                     i;
    int                     j;
    int                     rec_start;
    proc_cmd_v      = 1'b0;
    proc_cmd        = '0;
    proc_resp_ready = 1'b1;
    rec_v           = 1'b0;
    rec             = '0;
    @(posedge rst_n);
    assert (!proc_cmd_ready && !proc_resp_v && !done && !rec_ready &&
            finish == '0 && trace_en == '0)
      else abort_run("outputs are not low right after reset");
    @(negedge clk);
    assert (rec_ready)
      else abort_run("rec_ready_o did not rise the cycle after reset");

    test_name = "load_then_read";
    for (i = 0; i < 32; i++)
    begin
      ld_addrs.push_back(rand_addr(1'b0));
      load_record(io_platform_pkg::e_nbf_write, ld_addrs[$], next_random());
    end
    wait_loader_idle();
    foreach (ld_addrs[k])
      proc_access(1'b0, ld_addrs[k], '0);

    test_name = "finish_flags";
    for (i = 0; i < io_platform_pkg::NUM_CORES; i++)
    begin
      d = next_random();
      d[1:0] = 2'(i);
      proc_access(1'b1, io_platform_pkg::HOST_FINISH_ADDR, d);
      assert (finish == finish_model)
        else report_mismatch(io_platform_pkg::data_t'(finish_model),
                             io_platform_pkg::data_t'(finish));
      proc_access(1'b0, io_platform_pkg::HOST_FINISH_ADDR, '0);
    end

    test_name = "trace_enable";
    repeat (6)
    begin
      proc_access(1'b1, io_platform_pkg::HOST_TRACE_ADDR, next_random());
      assert (trace_en == trace_model)
        else report_mismatch(io_platform_pkg::data_t'(trace_model),
                             io_platform_pkg::data_t'(trace_en));
      proc_access(1'b0, io_platform_pkg::HOST_TRACE_ADDR, '0);
    end
    proc_access(1'b0, 16'h8002, '0);
    proc_access(1'b0, 16'hffff, '0);

    // Loader in the low half of memory, processor in the high half
    test_name = "contention";
    ld_addrs.delete();
    fork
      for (i = 0; i < 16; i++)
      begin
        ld_addrs.push_back(rand_addr(1'b0));
        load_record(io_platform_pkg::e_nbf_write, ld_addrs[$], next_random());
      end
      for (j = 0; j < 16; j++)
      begin
        pr_addrs.push_back(rand_addr(1'b1));
        proc_access(1'b1, pr_addrs[$], next_random());
      end
    join
    wait_loader_idle();
    foreach (ld_addrs[k])
      proc_access(1'b0, ld_addrs[k], '0);
    foreach (pr_addrs[k])
      proc_access(1'b0, pr_addrs[k], '0);

    test_name = "backpressure";
    bp_on = 1'b1;
    pr_addrs.delete();
    repeat (10)
    begin
      pr_addrs.push_back(rand_addr(1'b1));
      proc_access(1'b1, pr_addrs[$], next_random());
    end
    foreach (pr_addrs[k])
      proc_access(1'b0, pr_addrs[k], '0);
    bp_on = 1'b0;

    test_name = "loader_done";
    a = rand_addr(1'b0);
    load_record(io_platform_pkg::e_nbf_write, a, next_random());
    load_record(io_platform_pkg::e_nbf_fence, '0, '0);
    load_record(io_platform_pkg::e_nbf_finish, '0, '0);
    while (!done)
      @(negedge clk);
    // A further record must be refused
    rec_start = rec_accepts;
    rec_v = 1'b1;
    repeat (8)
    begin
      @(negedge clk);
      assert (done && !rec_ready)
        else abort_run("loader left the done state or accepted records after finish");
    end
    assert (rec_accepts == rec_start)
      else abort_run("loader accepted a record after the finish record");
    rec_v = 1'b0;
    proc_access(1'b0, a, '0);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- filelist.f
source/io_platform_pkg.sv
source/nbf_loader.sv
source/word_memory.sv
source/host_regs.sv
source/io_arbiter.sv
source/io_platform.sv
bench/tb_clock.sv
bench/tb_io_platform.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_io_platform -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

./obj_dir/Vtb_io_platform
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

exit 0
